// File: verilog/mmio_host_pkg.sv
// Host channel message kinds and widths, referenced by scoped name from every host-side module
`default_nettype none

package mmio_host_pkg;

    // ========================================================================
    // Message kinds carried on the single host channel
    // ========================================================================

    // Encoding 2'd3 is never sent by the host and the splitter drops it
    typedef enum logic [1:0] {
        KIND_MMIO_RD = 2'd0,
        KIND_MMIO_WR = 2'd1,
        KIND_MEM_RSP = 2'd2
    } msg_kind_t;

    // ========================================================================
    // Field widths
    // ========================================================================

    // MMIO byte address and transaction tag
    localparam int HOST_ADDR_W = 16;
    localparam int TID_W       = 9;

    // Full channel payload and the 8-byte read response
    localparam int HOST_DATA_W = 512;
    localparam int RSP_DATA_W  = 64;

    // Reads the host may have in flight, which is also the tag queue depth
    localparam int MMIO_RD_CREDITS = 4;

    // Tag queue pointer width, the depth is a power of two so pointers wrap
    localparam int TAGQ_PTR_W = $clog2(MMIO_RD_CREDITS);

endpackage

`default_nettype wire

// File: verilog/afu_csr_pkg.sv
// AFU register map constants, referenced by scoped name from the AFU and both Avalon masters
`default_nettype none

package afu_csr_pkg;

    // Register file of 64-bit words and the index that selects one
    localparam int CSR_WORDS = 16;
    localparam int CSR_IDX_W = 4;

    // Word index carried on the 64-bit master, the byte address less its low 3 bits
    localparam int AV64_ADDR_W = mmio_host_pkg::HOST_ADDR_W - 3;

    // Read-only identifier held in word 0
    localparam logic [63:0] AFU_ID = 64'h5a3c_0f1e_b2d4_7c91;

    // Line buffer in the upper half of the register file
    localparam int LINE_BASE_WORD = 8;
    localparam int LINE_WORDS     = 8;

    // Only byte address accepted by the 512-bit master
    localparam logic [15:0] LINE_BYTE_ADDR = 16'h0040;

endpackage

`default_nettype wire

// File: verilog/mmio_chan_split.sv
// Host channel register stages followed by a router that sends each message to one consumer
`default_nettype none
`timescale 1ns/1ps

module mmio_chan_split #(
    parameter int REG_STAGES = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   rx_valid,
    input  mmio_host_pkg::msg_kind_t               rx_kind,
    input  logic [mmio_host_pkg::HOST_ADDR_W-1:0]  rx_addr,
    input  logic [mmio_host_pkg::TID_W-1:0]        rx_tid,
    input  logic                                   rx_len64,
    input  logic [mmio_host_pkg::HOST_DATA_W-1:0]  rx_data,
    output logic                                   mmio64_valid,
    output logic                                   mmio64_is_read,
    output logic [mmio_host_pkg::HOST_ADDR_W-1:0]  mmio64_addr,
    output logic [mmio_host_pkg::TID_W-1:0]        mmio64_tid,
    output logic [mmio_host_pkg::RSP_DATA_W-1:0]   mmio64_data,
    output logic                                   mmio512_valid,
    output logic [mmio_host_pkg::HOST_ADDR_W-1:0]  mmio512_addr,
    output logic [mmio_host_pkg::HOST_DATA_W-1:0]  mmio512_data,
    output logic                                   mem_rsp_valid,
    output logic [mmio_host_pkg::HOST_DATA_W-1:0]  mem_rsp_data
);

    // ========================================================================
    // Timing register stages
    // ========================================================================

    // Only the valid bits are reset, the fields follow them through the stages
    logic [REG_STAGES-1:0]                  vld_q;
    mmio_host_pkg::msg_kind_t               kind_q  [REG_STAGES];
    logic [mmio_host_pkg::HOST_ADDR_W-1:0]  addr_q  [REG_STAGES];
    logic [mmio_host_pkg::TID_W-1:0]        tid_q   [REG_STAGES];
    logic                                   len64_q [REG_STAGES];
    logic [mmio_host_pkg::HOST_DATA_W-1:0]  data_q  [REG_STAGES];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= rx_valid;
            for (int i = 1; i < REG_STAGES; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        kind_q[0]  <= rx_kind;
        addr_q[0]  <= rx_addr;
        tid_q[0]   <= rx_tid;
        len64_q[0] <= rx_len64;
        data_q[0]  <= rx_data;
        for (int i = 1; i < REG_STAGES; i++) begin
            kind_q[i]  <= kind_q[i-1];
            addr_q[i]  <= addr_q[i-1];
            tid_q[i]   <= tid_q[i-1];
            len64_q[i] <= len64_q[i-1];
            data_q[i]  <= data_q[i-1];
        end
    end

    // ========================================================================
    // Routing at the last stage
    // ========================================================================

    logic is_rd;
    logic is_wr;

    assign is_rd = (kind_q[REG_STAGES-1] == mmio_host_pkg::KIND_MMIO_RD);
    assign is_wr = (kind_q[REG_STAGES-1] == mmio_host_pkg::KIND_MMIO_WR);

    // Every read takes the 64-bit path whatever its length, writes split on length
    assign mmio64_valid   = vld_q[REG_STAGES-1] && (is_rd || (is_wr && !len64_q[REG_STAGES-1]));
    assign mmio64_is_read = is_rd;
    assign mmio64_addr    = addr_q[REG_STAGES-1];
    assign mmio64_tid     = tid_q[REG_STAGES-1];
    assign mmio64_data    = data_q[REG_STAGES-1][mmio_host_pkg::RSP_DATA_W-1:0];

    // Wide writes use the full payload
    assign mmio512_valid = vld_q[REG_STAGES-1] && is_wr && len64_q[REG_STAGES-1];
    assign mmio512_addr  = addr_q[REG_STAGES-1];
    assign mmio512_data  = data_q[REG_STAGES-1];

    // Host memory responses leave on their own port
    assign mem_rsp_valid = vld_q[REG_STAGES-1] &&
                           (kind_q[REG_STAGES-1] == mmio_host_pkg::KIND_MEM_RSP);
    assign mem_rsp_data  = data_q[REG_STAGES-1];

endmodule

`default_nettype wire

// File: verilog/mmio_to_avalon.sv
// Bridges 8-byte MMIO traffic to the 64-bit Avalon master and returns read responses with credits
`default_nettype none
`timescale 1ns/1ps

module mmio_to_avalon (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   mmio64_valid,
    input  logic                                   mmio64_is_read,
    input  logic [mmio_host_pkg::HOST_ADDR_W-1:0]  mmio64_addr,
    input  logic [mmio_host_pkg::TID_W-1:0]        mmio64_tid,
    input  logic [mmio_host_pkg::RSP_DATA_W-1:0]   mmio64_data,
    input  logic [63:0]                            av64_readdata,
    input  logic                                   av64_readdatavalid,
    output logic [afu_csr_pkg::AV64_ADDR_W-1:0]    av64_address,
    output logic                                   av64_read,
    output logic                                   av64_write,
    output logic [63:0]                            av64_writedata,
    output logic                                   tx_valid,
    output logic [mmio_host_pkg::TID_W-1:0]        tx_tid,
    output logic [mmio_host_pkg::RSP_DATA_W-1:0]   tx_data,
    output logic                                   rd_credit
);

    // ========================================================================
    // Tag queue
    // ========================================================================

    // Pointers carry one extra bit so a full queue differs from an empty one
    logic [mmio_host_pkg::TID_W-1:0]       tag_mem [mmio_host_pkg::MMIO_RD_CREDITS];
    logic [mmio_host_pkg::TAGQ_PTR_W:0]    wr_ptr;
    logic [mmio_host_pkg::TAGQ_PTR_W:0]    rd_ptr;
    logic                                  tag_full;
    logic                                  rd_accept;

    assign tag_full =
        (wr_ptr[mmio_host_pkg::TAGQ_PTR_W] != rd_ptr[mmio_host_pkg::TAGQ_PTR_W]) &&
        (wr_ptr[mmio_host_pkg::TAGQ_PTR_W-1:0] == rd_ptr[mmio_host_pkg::TAGQ_PTR_W-1:0]);

    // A read that finds the queue full came without credit and is dropped
    assign rd_accept = mmio64_valid && mmio64_is_read && !tag_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (rd_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // The AFU answers in order, so each response belongs to the oldest tag
            if (av64_readdatavalid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            tag_mem[wr_ptr[mmio_host_pkg::TAGQ_PTR_W-1:0]] <= mmio64_tid;
        end
    end

    // ========================================================================
    // Request side
    // ========================================================================

    // Strobes are single-cycle pulses issued one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            av64_read  <= 1'b0;
            av64_write <= 1'b0;
        end else begin
            av64_read  <= rd_accept;
            av64_write <= mmio64_valid && !mmio64_is_read;
        end
    end

    // Byte address becomes a word index by dropping the offset within the word
    always_ff @(posedge clk) begin
        av64_address   <= mmio64_addr[mmio_host_pkg::HOST_ADDR_W-1:3];
        av64_writedata <= mmio64_data;
    end

    // ========================================================================
    // Response side
    // ========================================================================

    // Each response hands one credit back to the host in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_valid  <= 1'b0;
            rd_credit <= 1'b0;
        end else begin
            tx_valid  <= av64_readdatavalid;
            rd_credit <= av64_readdatavalid;
        end
    end

    always_ff @(posedge clk) begin
        tx_tid  <= tag_mem[rd_ptr[mmio_host_pkg::TAGQ_PTR_W-1:0]];
        tx_data <= av64_readdata;
    end

endmodule

`default_nettype wire

// File: verilog/mmio_to_avalon_wo.sv
// Bridges 64-byte MMIO writes to the 512-bit write-only Avalon master
`default_nettype none
`timescale 1ns/1ps

module mmio_to_avalon_wo (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   mmio512_valid,
    input  logic [mmio_host_pkg::HOST_ADDR_W-1:0]  mmio512_addr,
    input  logic [mmio_host_pkg::HOST_DATA_W-1:0]  mmio512_data,
    output logic [mmio_host_pkg::HOST_ADDR_W-1:0]  av512_address,
    output logic                                   av512_write,
    output logic [mmio_host_pkg::HOST_DATA_W-1:0]  av512_writedata
);

    // ========================================================================
    // Alignment filter
    // ========================================================================

    // A line write must start on a 64-byte boundary
    logic aligned;

    assign aligned = (mmio512_addr[5:0] == 6'd0);

    // Misaligned writes are swallowed here and never reach the AFU
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            av512_write <= 1'b0;
        end else begin
            av512_write <= mmio512_valid && aligned;
        end
    end

    // ========================================================================
    // Address and data
    // ========================================================================

    // The byte address goes out unchanged and the AFU decodes it
    always_ff @(posedge clk) begin
        av512_address   <= mmio512_addr;
        av512_writedata <= mmio512_data;
    end

endmodule

`default_nettype wire

// File: verilog/afu_csr.sv
// AFU register file with an identifier word, scratch words and a line buffer behind two Avalon masters
`default_nettype none
`timescale 1ns/1ps

module afu_csr (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [afu_csr_pkg::AV64_ADDR_W-1:0]    av64_address,
    input  logic                                   av64_read,
    input  logic                                   av64_write,
    input  logic [63:0]                            av64_writedata,
    input  logic [mmio_host_pkg::HOST_ADDR_W-1:0]  av512_address,
    input  logic                                   av512_write,
    input  logic [mmio_host_pkg::HOST_DATA_W-1:0]  av512_writedata,
    output logic [63:0]                            av64_readdata,
    output logic                                   av64_readdatavalid
);

    // ========================================================================
    // Address decode
    // ========================================================================

    // Word 0 is a constant, so storage begins at word 1
    logic [63:0]                        csr_q [1:afu_csr_pkg::CSR_WORDS-1];
    logic [afu_csr_pkg::CSR_IDX_W-1:0]  idx;
    logic                               in_range;
    logic                               line_hit;
    logic [63:0]                        rd_word;

    assign idx = av64_address[afu_csr_pkg::CSR_IDX_W-1:0];

    // Upper index bits must all be zero, otherwise the access misses the file
    assign in_range =
        (av64_address[afu_csr_pkg::AV64_ADDR_W-1:afu_csr_pkg::CSR_IDX_W] == '0);

    // Wide writes land only at the line buffer address
    assign line_hit = av512_write && (av512_address == afu_csr_pkg::LINE_BYTE_ADDR);

    // ========================================================================
    // Register writes
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 1; w < afu_csr_pkg::CSR_WORDS; w++) begin
                csr_q[w] <= '0;
            end
        end else begin
            // Writes to word 0 or outside the file are ignored
            if (av64_write && in_range && (idx != '0)) begin
                csr_q[idx] <= av64_writedata;
            end
            // A line write loads all eight words, lowest slice first, and
            // wins over a 64-bit write to the same word in the same cycle
            if (line_hit) begin
                for (int w = 0; w < afu_csr_pkg::LINE_WORDS; w++) begin
                    csr_q[afu_csr_pkg::LINE_BASE_WORD + w] <= av512_writedata[w*64 +: 64];
                end
            end
        end
    end

    // ========================================================================
    // Register reads
    // ========================================================================

    always_comb begin
        if (!in_range) begin
            rd_word = '0;
        end else if (idx == '0) begin
            rd_word = afu_csr_pkg::AFU_ID;
        end else begin
            rd_word = csr_q[idx];
        end
    end

    // Read data follows av64_read by exactly one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            av64_readdatavalid <= 1'b0;
        end else begin
            av64_readdatavalid <= av64_read;
        end
    end

    always_ff @(posedge clk) begin
        av64_readdata <= rd_word;
    end

endmodule

`default_nettype wire

// File: verilog/host_afu_top.sv
// Top level of the host channel shell, joining the splitter, both Avalon bridges and the AFU
`default_nettype none
`timescale 1ns/1ps

module host_afu_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   rx_valid,
    input  mmio_host_pkg::msg_kind_t               rx_kind,
    input  logic [mmio_host_pkg::HOST_ADDR_W-1:0]  rx_addr,
    input  logic [mmio_host_pkg::TID_W-1:0]        rx_tid,
    input  logic                                   rx_len64,
    input  logic [mmio_host_pkg::HOST_DATA_W-1:0]  rx_data,
    output logic                                   tx_valid,
    output logic [mmio_host_pkg::TID_W-1:0]        tx_tid,
    output logic [mmio_host_pkg::RSP_DATA_W-1:0]   tx_data,
    output logic                                   rd_credit
);

    // ========================================================================
    // Internal buses
    // ========================================================================

    // 8-byte MMIO path from the splitter
    logic                                   mmio64_valid;
    logic                                   mmio64_is_read;
    logic [mmio_host_pkg::HOST_ADDR_W-1:0]  mmio64_addr;
    logic [mmio_host_pkg::TID_W-1:0]        mmio64_tid;
    logic [mmio_host_pkg::RSP_DATA_W-1:0]   mmio64_data;

    // 64-byte MMIO write path from the splitter
    logic                                   mmio512_valid;
    logic [mmio_host_pkg::HOST_ADDR_W-1:0]  mmio512_addr;
    logic [mmio_host_pkg::HOST_DATA_W-1:0]  mmio512_data;

    // 64-bit Avalon master into the AFU
    logic [afu_csr_pkg::AV64_ADDR_W-1:0]    av64_address;
    logic                                   av64_read;
    logic                                   av64_write;
    logic [63:0]                            av64_writedata;
    logic [63:0]                            av64_readdata;
    logic                                   av64_readdatavalid;

    // 512-bit write-only Avalon master into the AFU
    logic [mmio_host_pkg::HOST_ADDR_W-1:0]  av512_address;
    logic                                   av512_write;
    logic [mmio_host_pkg::HOST_DATA_W-1:0]  av512_writedata;

    // ========================================================================
    // Channel split
    // ========================================================================

    // Host memory responses have no consumer here and fall on the floor
    mmio_chan_split #(
        .REG_STAGES(2)
    ) u_split (
        .clk            (clk),
        .rst_n          (rst_n),
        .rx_valid       (rx_valid),
        .rx_kind        (rx_kind),
        .rx_addr        (rx_addr),
        .rx_tid         (rx_tid),
        .rx_len64       (rx_len64),
        .rx_data        (rx_data),
        .mmio64_valid   (mmio64_valid),
        .mmio64_is_read (mmio64_is_read),
        .mmio64_addr    (mmio64_addr),
        .mmio64_tid     (mmio64_tid),
        .mmio64_data    (mmio64_data),
        .mmio512_valid  (mmio512_valid),
        .mmio512_addr   (mmio512_addr),
        .mmio512_data   (mmio512_data),
        .mem_rsp_valid  (),
        .mem_rsp_data   ()
    );

    // ========================================================================
    // Avalon bridges and the AFU
    // ========================================================================

    mmio_to_avalon u_av64 (
        .clk                (clk),
        .rst_n              (rst_n),
        .mmio64_valid       (mmio64_valid),
        .mmio64_is_read     (mmio64_is_read),
        .mmio64_addr        (mmio64_addr),
        .mmio64_tid         (mmio64_tid),
        .mmio64_data        (mmio64_data),
        .av64_readdata      (av64_readdata),
        .av64_readdatavalid (av64_readdatavalid),
        .av64_address       (av64_address),
        .av64_read          (av64_read),
        .av64_write         (av64_write),
        .av64_writedata     (av64_writedata),
        .tx_valid           (tx_valid),
        .tx_tid             (tx_tid),
        .tx_data            (tx_data),
        .rd_credit          (rd_credit)
    );

    mmio_to_avalon_wo u_av512 (
        .clk             (clk),
        .rst_n           (rst_n),
        .mmio512_valid   (mmio512_valid),
        .mmio512_addr    (mmio512_addr),
        .mmio512_data    (mmio512_data),
        .av512_address   (av512_address),
        .av512_write     (av512_write),
        .av512_writedata (av512_writedata)
    );

    // Both masters share one register file with no stalls
    afu_csr u_afu (
        .clk                (clk),
        .rst_n              (rst_n),
        .av64_address       (av64_address),
        .av64_read          (av64_read),
        .av64_write         (av64_write),
        .av64_writedata     (av64_writedata),
        .av512_address      (av512_address),
        .av512_write        (av512_write),
        .av512_writedata    (av512_writedata),
        .av64_readdata      (av64_readdata),
        .av64_readdatavalid (av64_readdatavalid)
    );

endmodule

`default_nettype wire

// File: bench/host_afu_tb.sv
// Testbench that drives host messages into the DUT, models the register map and checks responses
`default_nettype none
`timescale 1ns/1ps

module host_afu_tb;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   rx_valid;
    mmio_host_pkg::msg_kind_t               rx_kind;
    logic [mmio_host_pkg::HOST_ADDR_W-1:0]  rx_addr;
    logic [mmio_host_pkg::TID_W-1:0]        rx_tid;
    logic                                   rx_len64;
    logic [mmio_host_pkg::HOST_DATA_W-1:0]  rx_data;
    logic                                   tx_valid;
    logic [mmio_host_pkg::TID_W-1:0]        tx_tid;
    logic [mmio_host_pkg::RSP_DATA_W-1:0]   tx_data;
    logic                                   rd_credit;

    // Reference model of the register file and of the reads in flight
    logic [63:0]                      model [afu_csr_pkg::CSR_WORDS];
    logic [mmio_host_pkg::TID_W-1:0]  exp_tid [$];
    logic [63:0]                      exp_data [$];
    logic [mmio_host_pkg::TID_W-1:0]  next_tid;
    integer                           seed;
    int                               reads_sent;
    int                               credits_back;
    int                               value_errors;
    int                               proto_errors;
    int                               timeouts;
    int                               pulses_before;
    logic [mmio_host_pkg::HOST_DATA_W-1:0] line_data;

    host_afu_top u_host_afu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_valid  (rx_valid),
        .rx_kind   (rx_kind),
        .rx_addr   (rx_addr),
        .rx_tid    (rx_tid),
        .rx_len64  (rx_len64),
        .rx_data   (rx_data),
        .tx_valid  (tx_valid),
        .tx_tid    (tx_tid),
        .tx_data   (tx_data),
        .rd_credit (rd_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================================================
    // Response checking on the rising edge
    // ========================================================================

    // DUT outputs come from registers, so the values seen here are last cycle's
    always @(posedge clk) begin : check_rsp
        logic [mmio_host_pkg::TID_W-1:0] want_tid;
        logic [63:0]                     want_data;
        if (rst_n) begin
            assert (rd_credit === tx_valid) else begin
                proto_errors++;
                $display("[ERROR] %0t ns: rd_credit expected %b got %b",
                         $time, tx_valid, rd_credit);
            end
            if (rd_credit === 1'b1) begin
                credits_back++;
            end
            if (tx_valid === 1'b1) begin
                if (exp_tid.size() == 0) begin
                    proto_errors++;
                    $display("%0t ns: a read response arrived with no read outstanding", $time);
                end else begin
                    want_tid  = exp_tid.pop_front();
                    want_data = exp_data.pop_front();
                    assert (tx_tid === want_tid) else begin
                        value_errors++;
                        $display("[ERROR] %0t ns: tx_tid expected %0h got %0h",
                                 $time, want_tid, tx_tid);
                    end
                    assert (tx_data === want_data) else begin
                        value_errors++;
                        $display("[ERROR] %0t ns: tx_data expected %h got %h",
                                 $time, want_data, tx_data);
                    end
                end
            end
        end
    end

    // ========================================================================
    // Host stimulus tasks
    // ========================================================================

    task automatic send_msg(input mmio_host_pkg::msg_kind_t kind, input logic [15:0] addr,
                            input logic [8:0] tid, input logic len64,
                            input logic [511:0] data);
        @(negedge clk);
        rx_valid = 1'b1;
        rx_kind  = kind;
        rx_addr  = addr;
        rx_tid   = tid;
        rx_len64 = len64;
        rx_data  = data;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    // Holds the channel idle until a read credit is free
    task automatic wait_credit();
        int n;
        n = 0;
        while ((reads_sent - credits_back >= mmio_host_pkg::MMIO_RD_CREDITS) && (n < 100)) begin
            @(negedge clk);
            rx_valid = 1'b0;
            n++;
        end
        if (n >= 100) begin
            timeouts++;
            $display("%0t ns: no read credit came back within 100 cycles, read sent without one",
                     $time);
        end
    endtask

    task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
        // Word 0 and addresses past the file keep their value
        if ((addr < afu_csr_pkg::CSR_WORDS * 8) && (addr[6:3] != 4'd0)) begin
            model[addr[6:3]] = data;
        end
        send_msg(mmio_host_pkg::KIND_MMIO_WR, addr, 9'd0, 1'b0, {448'd0, data});
    endtask

    task automatic line_write(input logic [15:0] addr, input logic [511:0] data);
        if (addr == afu_csr_pkg::LINE_BYTE_ADDR) begin
            for (int k = 0; k < afu_csr_pkg::LINE_WORDS; k++) begin
                model[afu_csr_pkg::LINE_BASE_WORD + k] = data[k*64 +: 64];
            end
        end
        send_msg(mmio_host_pkg::KIND_MMIO_WR, addr, 9'd0, 1'b1, data);
    endtask

    task automatic mmio_read(input logic [15:0] addr);
        wait_credit();
        exp_tid.push_back(next_tid);
        if (addr < afu_csr_pkg::CSR_WORDS * 8) begin
            exp_data.push_back(model[addr[6:3]]);
        end else begin
            exp_data.push_back(64'd0);
        end
        reads_sent++;
        send_msg(mmio_host_pkg::KIND_MMIO_RD, addr, next_tid, 1'b0, 512'd0);
        next_tid = next_tid + 9'd3;
    endtask

    task automatic wait_idle();
        int n;
        drive_idle();
        n = 0;
        while ((exp_tid.size() != 0) && (n < 100)) begin
            @(negedge clk);
            n++;
        end
        if (n >= 100) begin
            timeouts++;
            $display("%0t ns: %0d read responses never came", $time, exp_tid.size());
            exp_tid.delete();
            exp_data.delete();
        end
        // Room for any stray response or credit to show up
        repeat (3) @(negedge clk);
    endtask

    task automatic check_quiet();
        assert ((tx_valid === 1'b0) && (rd_credit === 1'b0)) else begin
            proto_errors++;
            $display("[ERROR] %0t ns: tx_valid/rd_credit expected 0/0 got %b/%b",
                     $time, tx_valid, rd_credit);
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        seed         = 32'h7356b7b9;
        rst_n        = 1'b0;
        rx_valid     = 1'b0;
        rx_kind      = mmio_host_pkg::KIND_MMIO_RD;
        rx_addr      = '0;
        rx_tid       = '0;
        rx_len64     = 1'b0;
        rx_data      = '0;
        next_tid     = 9'h1a5;
        reads_sent   = 0;
        credits_back = 0;
        value_errors = 0;
        proto_errors = 0;
        timeouts     = 0;
        model[0]     = afu_csr_pkg::AFU_ID;
        for (int w = 1; w < afu_csr_pkg::CSR_WORDS; w++) begin
            model[w] = 64'd0;
        end

        // Outputs stay low through reset and just after it
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (i >= 1) begin
                check_quiet();
            end
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_quiet();
        end
        mmio_read(16'h0000);
        wait_idle();

        // Scratch words read back and word 0 ignores writes
        for (int w = 1; w < 8; w++) begin
            mmio_write(16'(w * 8), rand64());
        end
        mmio_write(16'h0000, rand64());
        for (int w = 0; w < 8; w++) begin
            mmio_read(16'(w * 8));
        end
        wait_idle();

        // Line buffer load, then wide writes elsewhere change nothing
        for (int k = 0; k < 16; k++) begin
            line_data[k*32 +: 32] = $random(seed);
        end
        line_write(afu_csr_pkg::LINE_BYTE_ADDR, line_data);
        for (int w = 8; w < 16; w++) begin
            mmio_read(16'(w * 8));
        end
        wait_idle();
        line_write(16'h0080, {8{rand64()}});
        line_write(16'h0044, {8{rand64()}});
        for (int w = 8; w < 16; w++) begin
            mmio_read(16'(w * 8));
        end
        wait_idle();

        // Back-to-back reads on full credits, then reissue on returned credits
        pulses_before = credits_back;
        for (int w = 1; w < 5; w++) begin
            mmio_read(16'(w * 8));
        end
        wait_idle();
        assert (credits_back - pulses_before == 4) else begin
            proto_errors++;
            $display("%0t ns: four reads returned %0d credits",
                     $time, credits_back - pulses_before);
        end
        pulses_before = credits_back;
        for (int w = 0; w < 6; w++) begin
            mmio_read(16'(w * 16));
        end
        wait_idle();
        assert (credits_back - pulses_before == 6) else begin
            proto_errors++;
            $display("%0t ns: six reads returned %0d credits",
                     $time, credits_back - pulses_before);
        end

        // Memory responses mixed with MMIO traffic, and reads past the file
        send_msg(mmio_host_pkg::KIND_MEM_RSP, afu_csr_pkg::LINE_BYTE_ADDR, 9'd7, 1'b1, ~line_data);
        mmio_write(16'h0010, rand64());
        send_msg(mmio_host_pkg::KIND_MEM_RSP, 16'h0018, 9'd9, 1'b0, {8{rand64()}});
        mmio_read(16'h0010);
        send_msg(mmio_host_pkg::KIND_MEM_RSP, 16'h0008, 9'd2, 1'b0, {8{rand64()}});
        mmio_read(16'h0018);
        mmio_read(16'h0080);
        mmio_read(16'h0400);
        mmio_read(16'hfff8);
        wait_idle();
        // Word 1 and the line buffer sat under memory response addresses
        mmio_read(16'h0008);
        for (int w = 8; w < 16; w++) begin
            mmio_read(16'(w * 8));
        end
        wait_idle();

        $display("Summary: value errors %0d, protocol errors %0d, timeouts %0d",
                 value_errors, proto_errors, timeouts);
        if (value_errors + proto_errors + timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: host_afu.f
verilog/mmio_host_pkg.sv
verilog/afu_csr_pkg.sv
verilog/mmio_chan_split.sv
verilog/mmio_to_avalon.sv
verilog/mmio_to_avalon_wo.sv
verilog/afu_csr.sv
verilog/host_afu_top.sv
bench/host_afu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the host_afu testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f host_afu.f --top-module host_afu_tb \
    -Mdir obj_dir -o host_afu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/host_afu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
